//--- run.sh
#!/bin/sh
# Builds the SMPC testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_smpc -f verilog.f -o tb_smpc
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/tb_smpc > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- smpc.sv
module smpc #(
	parameter logic [21:0] SEC_DIV = 22'd4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic       MRES_N,
	input  logic       TIME_SET,
	input  logic       SRES_N,
	input  logic [3:0] ac,
	input  logic [6:1] a,
	input  logic [7:0] di,
	input  logic       cs_n,
	input  logic       rw_n,
	output logic [7:0] do_q,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sysres_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);

	smpc_pkg::smpc_cmd_t     cmd;
	smpc_pkg::smpc_status_t  status;
	smpc_pkg::smpc_oreg_wr_t oreg_wr;
	smpc_pkg::smpc_time_t    time_bcd;
	smpc_pkg::smpc_lines_t   lines;
	logic                    cmd_req;
	logic                    cmd_ack;
	logic                    sf_set;
	logic [4:0]              oreg_raddr;
	logic [7:0]              oreg_q;

	smpc_host_regs u_host_regs (
		.CLK(CLK), .RST_N(RST_N), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n),
		.oreg_q(oreg_q), .status(status), .cmd_ack(cmd_ack), .do_q(do_q),
		.oreg_raddr(oreg_raddr), .cmd(cmd), .cmd_req(cmd_req), .sf_set(sf_set)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .MRES_N(MRES_N), .TIME_SET(TIME_SET),
		.SRES_N(SRES_N), .ac(ac), .cmd(cmd), .cmd_req(cmd_req), .sf_set(sf_set),
		.time_bcd(time_bcd), .cmd_ack(cmd_ack), .status(status), .oreg_wr(oreg_wr),
		.lines(lines), .mirq_n(mirq_n)
	);

	smpc_rtc #(.SEC_DIV(SEC_DIV)) u_rtc (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .time_bcd(time_bcd)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK(CLK), .wr(oreg_wr), .raddr(oreg_raddr), .q(oreg_q)
	);

	assign mshres_n = lines.mshres_n;
	assign mshnmi_n = lines.mshnmi_n;
	assign sshres_n = lines.sshres_n;
	assign sshnmi_n = lines.sshnmi_n;
	assign sysres_n = lines.sysres_n;
	assign sndres_n = lines.sndres_n;
	assign cdres_n = lines.cdres_n;

endmodule

//--- smpc_cmd_seq.sv
module smpc_cmd_seq (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    CE,
	input  logic                    MRES_N,
	input  logic                    TIME_SET,
	input  logic                    SRES_N,
	input  logic [3:0]              ac,
	input  smpc_pkg::smpc_cmd_t     cmd,
	input  logic                    cmd_req,
	input  logic                    sf_set,
	input  smpc_pkg::smpc_time_t    time_bcd,
	output logic                    cmd_ack,
	output smpc_pkg::smpc_status_t  status,
	output smpc_pkg::smpc_oreg_wr_t oreg_wr,
	output smpc_pkg::smpc_lines_t   lines,
	output logic                    mirq_n
);

	typedef enum logic [2:0] {ST_IDLE, ST_START, ST_WAIT, ST_EXEC, ST_END} state_t;

	state_t              state;
	smpc_pkg::smpc_cmd_t cmd_q;
	logic [7:0]          sr;
	logic                sf;
	logic                resd;
	logic                ste;
	logic                sres_lock;
	logic [15:0]         wait_cnt;
	logic [15:0]         sres_cnt;
	logic [4:0]          oreg_cnt;
	logic [7:0]          smem [4];
	logic [7:0]          status_byte;
	logic                start_cmd;
	logic                smem_we;
	logic                intback_run;
	logic                exec_last;

	function automatic logic [15:0] wait_for(input logic [7:0] code);
		case (code)
			smpc_pkg::CMD_MSHON, smpc_pkg::CMD_SSHON, smpc_pkg::CMD_SSHOFF,
			smpc_pkg::CMD_SNDON, smpc_pkg::CMD_SNDOFF:   return smpc_pkg::WAIT_SHORT;
			smpc_pkg::CMD_CDON, smpc_pkg::CMD_CDOFF,
			smpc_pkg::CMD_SETSMEM:                       return smpc_pkg::WAIT_CD;
			smpc_pkg::CMD_SYSRES:                        return smpc_pkg::WAIT_SYS;
			smpc_pkg::CMD_INTBACK:                       return smpc_pkg::WAIT_INTBACK;
			smpc_pkg::CMD_SETTIME:                       return smpc_pkg::WAIT_TIME;
			smpc_pkg::CMD_NMIREQ, smpc_pkg::CMD_RESENAB,
			smpc_pkg::CMD_RESDISA:                       return smpc_pkg::WAIT_NMI;
			default:                                     return 16'd0;
		endcase
	endfunction

	assign status = {sr, sf};

	assign start_cmd = CE && MRES_N && state == ST_IDLE && cmd_req && !cmd_ack &&
		sres_cnt == 16'd0;
	assign smem_we = CE && MRES_N && state == ST_EXEC && cmd_q.code == smpc_pkg::CMD_SETSMEM;

	// Status INTBACK needs IREG0 bit 0 and the F0 marker in IREG2
	assign intback_run = cmd_q.code == smpc_pkg::CMD_INTBACK && cmd_q.ireg0[0] &&
		cmd_q.ireg2 == 8'hF0;
	assign exec_last = !intback_run || oreg_cnt == smpc_pkg::OREG_RESULT;

	always_comb begin
		case (oreg_cnt)
			5'd0:  status_byte = {ste, resd, 6'd0};
			5'd1:  status_byte = 8'h20;	// Year 2022
			5'd2:  status_byte = 8'h22;
			5'd3:  status_byte = 8'h01;	// Weekday and month
			5'd4:  status_byte = time_bcd.day;
			5'd5:  status_byte = time_bcd.hour;
			5'd6:  status_byte = time_bcd.min;
			5'd7:  status_byte = time_bcd.sec;
			5'd9:  status_byte = {4'd0, ac};
			5'd10: status_byte = {4'b0011, ~lines.mshnmi_n, 1'b1, ~lines.sysres_n, ~lines.sndres_n};
			5'd11: status_byte = {1'b0, ~lines.cdres_n, 6'd0};
			5'd12: status_byte = smem[0];
			5'd13: status_byte = smem[1];
			5'd14: status_byte = smem[2];
			5'd15: status_byte = smem[3];
			smpc_pkg::OREG_RESULT: status_byte = cmd_q.code;
			default: status_byte = 8'h00;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (start_cmd) begin
			cmd_q <= cmd;
		end
		if (smem_we) begin
			smem[0] <= cmd_q.ireg0;
			smem[1] <= cmd_q.ireg1;
			smem[2] <= cmd_q.ireg2;
			smem[3] <= cmd_q.ireg3;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			cmd_ack <= 1'b0;
			sr <= 8'h00;
			sf <= 1'b0;
			resd <= 1'b1;
			ste <= 1'b0;
			lines <= '0;
			mirq_n <= 1'b1;
			oreg_wr <= '0;
			wait_cnt <= 16'd0;
			sres_cnt <= 16'd0;
			sres_lock <= 1'b0;
			oreg_cnt <= 5'd0;
		end else if (!MRES_N) begin
			state <= ST_IDLE;	// Boot hold
			if (!cmd_req) begin
				cmd_ack <= 1'b0;
			end
			oreg_wr.we <= 1'b0;
			lines <= '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0, sshnmi_n: 1'b1,
				sysres_n: 1'b1, sndres_n: 1'b0, cdres_n: 1'b1};
			mirq_n <= 1'b1;
			sr <= {smpc_pkg::SR_IDLE, 5'd0};
			resd <= 1'b1;
			ste <= TIME_SET;
			sres_cnt <= 16'd0;
			sres_lock <= 1'b0;
		end else begin
			oreg_wr.we <= 1'b0;
			if (cmd_ack && !cmd_req) begin
				cmd_ack <= 1'b0;
			end

			if (CE) begin
				sr[4] <= ~SRES_N;

				// Reset button NMI, re-armed once SRES_N is released
				if (!SRES_N && !resd && !sres_lock) begin
					lines.mshnmi_n <= 1'b0;
					lines.sshnmi_n <= 1'b0;
					sres_cnt <= smpc_pkg::WAIT_SRES;
					sres_lock <= 1'b1;
				end else if (sres_cnt != 16'd0) begin
					sres_cnt <= sres_cnt - 16'd1;
					if (sres_cnt == 16'd1) begin
						lines.mshnmi_n <= 1'b1;
						lines.sshnmi_n <= 1'b1;
					end
				end else if (SRES_N) begin
					sres_lock <= 1'b0;
				end

				case (state)
					ST_IDLE: begin
						mirq_n <= 1'b1;
						if (start_cmd) begin
							cmd_ack <= 1'b1;
							sr[7:5] <= smpc_pkg::SR_IDLE;
							oreg_cnt <= 5'd0;
							state <= ST_START;
						end
					end

					ST_START: begin
						wait_cnt <= wait_for(cmd_q.code);
						state <= ST_WAIT;
					end

					ST_WAIT: begin
						if (wait_cnt == 16'd0) begin
							state <= ST_EXEC;
						end else begin
							wait_cnt <= wait_cnt - 16'd1;
						end
					end

					ST_EXEC: begin
						oreg_wr.we <= 1'b1;
						if (intback_run) begin
							oreg_wr.addr <= oreg_cnt;	// One OREG per cycle
							oreg_wr.data <= status_byte;
							oreg_cnt <= oreg_cnt + 5'd1;
						end else begin
							oreg_wr.addr <= smpc_pkg::OREG_RESULT;
							oreg_wr.data <= cmd_q.code;
						end
						if (exec_last) begin
							sf <= 1'b0;
							state <= ST_END;
						end

						case (cmd_q.code)
							smpc_pkg::CMD_MSHON: begin
								lines.mshres_n <= 1'b1;
								lines.mshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHON: begin
								lines.sshres_n <= 1'b1;
								lines.sshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SSHOFF: begin
								lines.sshres_n <= 1'b0;
								lines.sshnmi_n <= 1'b1;
							end
							smpc_pkg::CMD_SNDON:  lines.sndres_n <= 1'b1;
							smpc_pkg::CMD_SNDOFF: lines.sndres_n <= 1'b0;
							smpc_pkg::CMD_CDON:   lines.cdres_n <= 1'b1;
							smpc_pkg::CMD_CDOFF:  lines.cdres_n <= 1'b0;
							smpc_pkg::CMD_SYSRES: lines <= '0;	// Released again in end state
							smpc_pkg::CMD_INTBACK: begin
								if (intback_run && oreg_cnt == smpc_pkg::OREG_RESULT) begin
									sr[7:5] <= smpc_pkg::SR_INTBACK_DONE;
									mirq_n <= 1'b0;
								end
							end
							smpc_pkg::CMD_SETTIME: ste <= 1'b1;
							smpc_pkg::CMD_NMIREQ:  lines.mshnmi_n <= 1'b0;
							smpc_pkg::CMD_RESENAB: resd <= 1'b0;
							smpc_pkg::CMD_RESDISA: resd <= 1'b1;
							default: ;
						endcase
					end

					ST_END: begin
						if (cmd_q.code == smpc_pkg::CMD_SYSRES) begin
							lines <= '1;
						end else if (cmd_q.code == smpc_pkg::CMD_NMIREQ) begin
							lines.mshnmi_n <= 1'b1;
						end
						state <= ST_IDLE;
					end

					default: state <= ST_IDLE;
				endcase
			end

			if (sf_set) begin
				sf <= 1'b1;
			end
		end
	end

endmodule

//--- smpc_host_regs.sv
module smpc_host_regs (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic [6:1]             a,
	input  logic [7:0]             di,
	input  logic                   cs_n,
	input  logic                   rw_n,
	input  logic [7:0]             oreg_q,
	input  smpc_pkg::smpc_status_t status,
	input  logic                   cmd_ack,
	output logic [7:0]             do_q,
	output logic [4:0]             oreg_raddr,
	output smpc_pkg::smpc_cmd_t    cmd,
	output logic                   cmd_req,
	output logic                   sf_set
);

	logic [6:1] a_s;
	logic [7:0] di_s;
	logic       cs_s;
	logic       rw_s;
	logic       cs_old;
	logic       rw_old;
	logic [6:0] full_addr;
	logic       wr_edge;
	logic       rd_edge;
	logic [7:0] rd_data;
	logic [7:0] comreg;
	logic [7:0] ireg [7];

	assign full_addr = {a_s, 1'b1};
	assign wr_edge = !rw_s && rw_old && !cs_s;	// RW_N falling with CS_N low
	assign rd_edge = !cs_s && cs_old && rw_s;	// CS_N falling in a read

	// OREG 0 sits at address 21, so index is A - 16
	assign oreg_raddr = a_s[5:1] - 5'd16;

	assign cmd = {comreg, ireg[0], ireg[1], ireg[2], ireg[3]};

	always_comb begin
		if (full_addr >= smpc_pkg::ADDR_OREG_FIRST && full_addr <= smpc_pkg::ADDR_OREG_LAST) begin
			rd_data = oreg_q;
		end else if (full_addr == smpc_pkg::ADDR_SR) begin
			rd_data = status.sr;
		end else if (full_addr == smpc_pkg::ADDR_SF) begin
			rd_data = {7'd0, status.sf};
		end else begin
			rd_data = 8'h00;
		end
	end

	always_ff @(posedge CLK) begin
		a_s <= a;
		di_s <= di;
		if (wr_edge) begin
			if (full_addr <= smpc_pkg::ADDR_IREG0 + 7'd12) begin
				ireg[full_addr[3:1]] <= di_s;	// IREG0..6
			end
			if (full_addr == smpc_pkg::ADDR_COMREG) begin
				comreg <= di_s;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_s <= 1'b1;
			rw_s <= 1'b1;
			cs_old <= 1'b1;
			rw_old <= 1'b1;
			cmd_req <= 1'b0;
			sf_set <= 1'b0;
			do_q <= 8'h00;
		end else begin
			cs_s <= cs_n;
			rw_s <= rw_n;
			cs_old <= cs_s;
			rw_old <= rw_s;

			sf_set <= wr_edge && full_addr == smpc_pkg::ADDR_SF && di_s[0];

			// Request side of the command handshake
			if (cmd_ack) begin
				cmd_req <= 1'b0;
			end else if (wr_edge && full_addr == smpc_pkg::ADDR_COMREG && !cmd_req) begin
				cmd_req <= 1'b1;
			end

			if (rd_edge) begin
				do_q <= rd_data;
			end
		end
	end

endmodule

//--- smpc_oreg_ram.sv
module smpc_oreg_ram (
	input  logic                    CLK,
	input  smpc_pkg::smpc_oreg_wr_t wr,
	input  logic [4:0]              raddr,
	output logic [7:0]              q
);

	logic [7:0] mem [32];

	always_ff @(posedge CLK) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.data;
		end
	end

	assign q = mem[raddr];	// Asynchronous read port

endmodule

//--- smpc_pkg.sv
package smpc_pkg;

	// Command codes
	localparam logic [7:0] CMD_MSHON   = 8'h00;
	localparam logic [7:0] CMD_SSHON   = 8'h02;
	localparam logic [7:0] CMD_SSHOFF  = 8'h03;
	localparam logic [7:0] CMD_SNDON   = 8'h06;
	localparam logic [7:0] CMD_SNDOFF  = 8'h07;
	localparam logic [7:0] CMD_CDON    = 8'h08;
	localparam logic [7:0] CMD_CDOFF   = 8'h09;
	localparam logic [7:0] CMD_SYSRES  = 8'h0D;
	localparam logic [7:0] CMD_INTBACK = 8'h10;
	localparam logic [7:0] CMD_SETTIME = 8'h16;
	localparam logic [7:0] CMD_SETSMEM = 8'h17;
	localparam logic [7:0] CMD_NMIREQ  = 8'h18;
	localparam logic [7:0] CMD_RESENAB = 8'h19;
	localparam logic [7:0] CMD_RESDISA = 8'h1A;

	// Full odd register addresses
	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;

	// Command wait times in CE cycles
	localparam logic [15:0] WAIT_SHORT   = 16'd120;
	localparam logic [15:0] WAIT_CD      = 16'd159;
	localparam logic [15:0] WAIT_SYS     = 16'd400;
	localparam logic [15:0] WAIT_INTBACK = 16'd500;
	localparam logic [15:0] WAIT_TIME    = 16'd279;
	localparam logic [15:0] WAIT_NMI     = 16'd127;
	localparam logic [15:0] WAIT_SRES    = 16'd60000;

	localparam logic [2:0] SR_INTBACK_DONE = 3'b010;
	localparam logic [2:0] SR_IDLE         = 3'b000;

	localparam logic [4:0] OREG_RESULT = 5'd31;

	typedef struct packed {
		logic [7:0] code;
		logic [7:0] ireg0;
		logic [7:0] ireg1;
		logic [7:0] ireg2;
		logic [7:0] ireg3;
	} smpc_cmd_t;

	typedef struct packed {
		logic [7:0] sr;
		logic       sf;
	} smpc_status_t;

	typedef struct packed {
		logic       we;
		logic [4:0] addr;
		logic [7:0] data;
	} smpc_oreg_wr_t;

	typedef struct packed {
		logic [7:0] day;
		logic [7:0] hour;
		logic [7:0] min;
		logic [7:0] sec;
	} smpc_time_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sysres_n;
		logic sndres_n;
		logic cdres_n;
	} smpc_lines_t;

endpackage

//--- smpc_rtc.sv
module smpc_rtc #(
	parameter logic [21:0] SEC_DIV = 22'd4000000
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 CE,
	output smpc_pkg::smpc_time_t time_bcd
);

	logic [21:0] div_cnt;
	logic        sec_tick;
	logic [8:0]  sec_nx;
	logic [8:0]  min_nx;
	logic [8:0]  hour_nx;
	logic [8:0]  day_nx;

	// Next BCD value with carry out in bit 8
	function automatic logic [8:0] bcd_step(input logic [7:0] v, input logic [7:0] last);
		if (v == last) begin
			return 9'h100;
		end else if (v[3:0] == 4'd9) begin
			return {1'b0, v[7:4] + 4'd1, 4'd0};
		end else begin
			return {1'b0, v[7:4], v[3:0] + 4'd1};
		end
	endfunction

	assign sec_tick = div_cnt == SEC_DIV - 22'd1;

	assign sec_nx = bcd_step(time_bcd.sec, 8'h59);
	assign min_nx = bcd_step(time_bcd.min, 8'h59);
	assign hour_nx = bcd_step(time_bcd.hour, 8'h23);
	assign day_nx = bcd_step(time_bcd.day, 8'h99);	// Day wraps 99 to 00

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= 22'd0;
			time_bcd <= '0;
		end else if (CE) begin
			if (sec_tick) begin
				div_cnt <= 22'd0;
				time_bcd.sec <= sec_nx[7:0];
				if (sec_nx[8]) begin
					time_bcd.min <= min_nx[7:0];
					if (min_nx[8]) begin
						time_bcd.hour <= hour_nx[7:0];
						if (hour_nx[8]) begin
							time_bcd.day <= day_nx[7:0];
						end
					end
				end
			end else begin
				div_cnt <= div_cnt + 22'd1;
			end
		end
	end

endmodule

//--- tb_smpc_tests.svh
`ifndef TB_SMPC_TESTS_SVH
`define TB_SMPC_TESTS_SVH

// Line order: mshres, mshnmi, sshres, sshnmi, sysres, sndres, cdres
localparam logic [6:0] LINES_RESET = 7'b0000000;
localparam logic [6:0] LINES_BOOT  = 7'b1101101;
localparam logic [6:0] LINES_ALL   = 7'b1111111;

function automatic logic [6:0] line_vec();
	return {mshres_n, mshnmi_n, sshres_n, sshnmi_n, sysres_n, sndres_n, cdres_n};
endfunction

function automatic logic [6:0] oreg_addr(input logic [4:0] idx);
	return smpc_pkg::ADDR_OREG_FIRST + {1'b0, idx, 1'b0};
endfunction

function automatic logic bcd_valid(input logic [7:0] v, input logic [7:0] max);
	return v[3:0] <= 4'd9 && v[7:4] <= 4'd9 && v <= max;
endfunction

function automatic int bcd_to_int(input logic [7:0] v);
	return int'(v[7:4]) * 10 + int'(v[3:0]);
endfunction

task automatic apply_reset();
	RST_N = 1'b0;
	wait_cycles(3);
	RST_N = 1'b1;
	wait_cycles(1);
endtask

task automatic pulse_mres();
	MRES_N = 1'b0;
	wait_cycles(3);
	MRES_N = 1'b1;
	wait_cycles(2);
endtask

task automatic read_oreg(input logic [4:0] idx, output logic [7:0] data);
	bus_read(oreg_addr(idx), data);
endtask

task automatic line_step(input string name, input logic [7:0] code, input logic [6:0] exp_lines);
	logic [7:0] d;
	run_cmd(code, 8'h00, 8'h00, 8'h00, 8'h00);
	check_eq(name, 32'(exp_lines), 32'(line_vec()));
	read_oreg(smpc_pkg::OREG_RESULT, d);
	check_eq({name, "_oreg31"}, 32'(code), 32'(d));
endtask

task automatic test_reset_boot();
	logic [7:0] d;
	apply_reset();
	check_eq("reset_lines", 32'(LINES_RESET), 32'(line_vec()));
	check_eq("reset_mirq", 32'd1, 32'(mirq_n));
	pulse_mres();
	check_eq("boot_lines", 32'(LINES_BOOT), 32'(line_vec()));
	bus_read(smpc_pkg::ADDR_SR, d);
	check_eq("boot_sr", 32'h0, 32'(d));
endtask

task automatic test_line_cmds();
	line_step("sshon", smpc_pkg::CMD_SSHON, 7'b1111101);
	line_step("sshoff", smpc_pkg::CMD_SSHOFF, 7'b1101101);
	line_step("sndon", smpc_pkg::CMD_SNDON, 7'b1101111);
	line_step("cdoff", smpc_pkg::CMD_CDOFF, 7'b1101110);
endtask

task automatic test_sysres_nmi();
	line_step("sysres", smpc_pkg::CMD_SYSRES, LINES_ALL);	// Every line pulsed and released
	line_step("nmireq", smpc_pkg::CMD_NMIREQ, LINES_ALL);
endtask

task automatic test_intback_status();
	logic [7:0] smem_val [4];
	logic [7:0] t_bcd [4];
	logic [7:0] d;
	int falls_before;
	int total_sec;
	int exp_sec;
	for (int i = 0; i < 4; i++) begin
		smem_val[i] = 8'($urandom);
	end
	run_cmd(smpc_pkg::CMD_SETSMEM, smem_val[0], smem_val[1], smem_val[2], smem_val[3]);
	run_cmd(smpc_pkg::CMD_SETTIME, 8'h00, 8'h00, 8'h00, 8'h00);
	falls_before = mirq_falls;
	run_cmd(smpc_pkg::CMD_INTBACK, 8'h01, 8'h00, 8'hF0, 8'h00);
	check_eq("intback_mirq_fall", 32'(falls_before + 1), 32'(mirq_falls));

	bus_read(smpc_pkg::ADDR_SR, d);
	check_eq("intback_sr", 32'(smpc_pkg::SR_INTBACK_DONE), 32'(d[7:5]));
	read_oreg(5'd0, d);
	check_eq("intback_oreg0", 32'hC0, 32'(d));	// RESD and STE both set
	read_oreg(5'd9, d);
	check_eq("intback_ac", 32'(ac), 32'(d));
	for (int i = 0; i < 4; i++) begin
		read_oreg(5'(12 + i), d);
		check_eq($sformatf("intback_smem%0d", i), 32'(smem_val[i]), 32'(d));
	end

	for (int i = 0; i < 4; i++) begin
		read_oreg(5'(4 + i), t_bcd[i]);
	end
	check_eq("intback_day_bcd", 32'd1, 32'(bcd_valid(t_bcd[0], 8'h99)));
	check_eq("intback_hour_bcd", 32'd1, 32'(bcd_valid(t_bcd[1], 8'h23)));
	check_eq("intback_min_bcd", 32'd1, 32'(bcd_valid(t_bcd[2], 8'h59)));
	check_eq("intback_sec_bcd", 32'd1, 32'(bcd_valid(t_bcd[3], 8'h59)));

	// Minutes folded in for a run that crosses a minute
	total_sec = bcd_to_int(t_bcd[2]) * 60 + bcd_to_int(t_bcd[3]);
	exp_sec = mirq_fall_cycle / SEC_CYCLES;
	if (total_sec >= exp_sec - 1 && total_sec <= exp_sec + 1) begin
		total_sec = exp_sec;
	end
	check_eq("intback_seconds", 32'(exp_sec), 32'(total_sec));
	read_oreg(smpc_pkg::OREG_RESULT, d);
	check_eq("intback_oreg31", 32'(smpc_pkg::CMD_INTBACK), 32'(d));
endtask

task automatic test_reset_button();
	logic fell;
	run_cmd(smpc_pkg::CMD_RESENAB, 8'h00, 8'h00, 8'h00, 8'h00);
	SRES_N = 1'b0;
	fell = 1'b0;
	for (int i = 0; i < 5 && !fell; i++) begin
		wait_cycles(1);
		if (!mshnmi_n) begin
			fell = 1'b1;
		end
	end
	check_eq("sres_nmi_fall", 32'd1, 32'(fell));
	SRES_N = 1'b1;

	apply_reset();
	pulse_mres();
	// Enable first so that RESDISA has something to undo
	run_cmd(smpc_pkg::CMD_RESENAB, 8'h00, 8'h00, 8'h00, 8'h00);
	run_cmd(smpc_pkg::CMD_RESDISA, 8'h00, 8'h00, 8'h00, 8'h00);
	SRES_N = 1'b0;
	repeat (100) begin
		wait_cycles(1);
		check_eq("sres_blocked", 32'd1, 32'(mshnmi_n));
	end
	SRES_N = 1'b1;
	wait_cycles(2);
endtask

`endif

//--- tb_smpc.sv
module tb_smpc;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEC_CYCLES = 50;
	localparam int SF_POLL_LIMIT = 400;
	// Longest test needs well under 10k cycles, so 2 ms leaves a wide margin
	localparam int WATCHDOG_NS = 2_000_000;

	logic       CLK;
	logic       RST_N;
	logic       CE;
	logic       MRES_N;
	logic       TIME_SET;
	logic       SRES_N;
	logic [3:0] ac;
	logic [6:1] a;
	logic [7:0] di;
	logic       cs_n;
	logic       rw_n;
	logic [7:0] do_q;
	logic       mshres_n;
	logic       mshnmi_n;
	logic       sshres_n;
	logic       sshnmi_n;
	logic       sysres_n;
	logic       sndres_n;
	logic       cdres_n;
	logic       mirq_n;

	int          cycle_cnt = 0;
	int          mirq_falls = 0;
	int          mirq_fall_cycle = 0;
	logic        mirq_q = 1'b1;

	smpc #(.SEC_DIV(22'(SEC_CYCLES))) uut (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .MRES_N(MRES_N), .TIME_SET(TIME_SET),
		.SRES_N(SRES_N), .ac(ac), .a(a), .di(di), .cs_n(cs_n), .rw_n(rw_n),
		.do_q(do_q), .mshres_n(mshres_n), .mshnmi_n(mshnmi_n), .sshres_n(sshres_n),
		.sshnmi_n(sshnmi_n), .sysres_n(sysres_n), .sndres_n(sndres_n),
		.cdres_n(cdres_n), .mirq_n(mirq_n)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Cycle count since reset and sticky record of MIRQ_N falls
	always @(negedge CLK) begin
		if (!RST_N) begin
			cycle_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
		if (mirq_q && !mirq_n) begin
			mirq_falls <= mirq_falls + 1;
			mirq_fall_cycle <= cycle_cnt;
		end
		mirq_q <= mirq_n;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("watchdog expired before the tests finished");
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			stop_on_error($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	// Write strobe is RW_N falling while CS_N is low
	task automatic bus_write(input logic [6:0] addr, input logic [7:0] data);
		a = addr[6:1];
		di = data;
		rw_n = 1'b1;
		cs_n = 1'b0;
		wait_cycles(2);
		rw_n = 1'b0;
		wait_cycles(3);
		rw_n = 1'b1;
		wait_cycles(1);
		cs_n = 1'b1;
		wait_cycles(2);
	endtask

	task automatic bus_read(input logic [6:0] addr, output logic [7:0] data);
		a = addr[6:1];
		rw_n = 1'b1;
		cs_n = 1'b1;
		wait_cycles(2);
		cs_n = 1'b0;
		wait_cycles(3);	// DO settles two cycles after CS_N falls
		data = do_q;
		cs_n = 1'b1;
		wait_cycles(1);
	endtask

	task automatic wait_sf_clear();
		logic [7:0] d;
		int polls;
		polls = 0;
		d = 8'h01;
		while (d[0]) begin
			if (polls == SF_POLL_LIMIT) begin
				stop_on_error($sformatf("SF did not clear after %0d status reads", polls));
			end
			bus_read(smpc_pkg::ADDR_SF, d);
			polls = polls + 1;
		end
	endtask

	task automatic run_cmd(input logic [7:0] code, input logic [7:0] i0, input logic [7:0] i1,
		input logic [7:0] i2, input logic [7:0] i3);
		bus_write(smpc_pkg::ADDR_IREG0, i0);
		bus_write(smpc_pkg::ADDR_IREG0 + 7'd2, i1);
		bus_write(smpc_pkg::ADDR_IREG0 + 7'd4, i2);
		bus_write(smpc_pkg::ADDR_IREG0 + 7'd6, i3);
		bus_write(smpc_pkg::ADDR_COMREG, code);
		bus_write(smpc_pkg::ADDR_SF, 8'h01);
		wait_sf_clear();
	endtask

	`include "tb_smpc_tests.svh"

	initial begin
		void'($urandom(2));
		RST_N = 1'b0;
		CE = 1'b1;
		MRES_N = 1'b1;
		TIME_SET = 1'b0;
		SRES_N = 1'b1;
		ac = 4'($urandom);
		a = 6'd0;
		di = 8'h00;
		cs_n = 1'b1;
		rw_n = 1'b1;

		test_reset_boot();
		test_line_cmds();
		test_sysres_nmi();
		test_intback_status();
		test_reset_button();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
smpc_pkg.sv
smpc_oreg_ram.sv
smpc_rtc.sv
smpc_host_regs.sv
smpc_cmd_seq.sv
smpc.sv
tb_smpc.sv
